// ==== rvcore_pkg.sv ====
`default_nettype none

package rvcore_pkg;

  // ******************************
  // Constants
  // ******************************
  localparam int xlen = 32;
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

  // Major opcodes, encoded as insn[6:0]
  typedef enum logic [6:0] {
    op      = 7'b0110011,
    op_imm  = 7'b0010011,
    lui     = 7'b0110111,
    jal     = 7'b1101111,
    branch  = 7'b1100011,
    load    = 7'b0000011,
    store   = 7'b0100011,
    illegal = 7'b0000000
  } opcode_e;

  typedef enum logic [3:0] {
    add,
    sub,
    and_op,
    or_op,
    xor_op,
    slt,
    sll,
    srl,
    pass_b  // LUI
  } alu_op_e;

  // ******************************
  // Stage payloads
  // ******************************
  typedef struct packed {
    opcode_e         opcode;
    alu_op_e         alu_op;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [xlen-1:0] imm;
    logic            use_imm;
    logic            reg_write;
    logic            is_branch;
    logic            branch_ne;  // BNE when set, BEQ otherwise
    logic            is_jump;
    logic            is_load;
    logic            is_store;
    logic            illegal;
  } decoded_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [31:0]     insn;
  } fetch_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic            en;
    logic [4:0]      addr;
    logic [xlen-1:0] data;
  } reg_write_t;

  // ******************************
  // Memory ports and trace
  // ******************************
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] addr;
  } imem_req_t;

  typedef struct packed {
    logic            ready;
    logic [31:0]     rdata;
  } imem_rsp_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [3:0]      wstrb;  // Zero for a read
  } dmem_req_t;

  typedef struct packed {
    logic            ready;
    logic [xlen-1:0] rdata;
  } dmem_rsp_t;

  typedef struct packed {
    logic            valid;
    logic [63:0]     order;
    logic [31:0]     insn;
    logic            trap;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [xlen-1:0] rs1_rdata;
    logic [xlen-1:0] rs2_rdata;
    logic [4:0]      rd_addr;
    logic [xlen-1:0] rd_wdata;
    logic [xlen-1:0] pc_rdata;
    logic [xlen-1:0] pc_wdata;
    logic [xlen-1:0] mem_addr;
    logic [3:0]      mem_rmask;
    logic [3:0]      mem_wmask;
    logic [xlen-1:0] mem_rdata;
    logic [xlen-1:0] mem_wdata;
  } retire_t;

endpackage

`default_nettype wire

// ==== decoder.sv ====
`default_nettype none

module decoder (
  input  logic [31:0]          insn,
  output rvcore_pkg::decoded_t dec
);

  logic [2:0]                     funct3;
  logic [6:0]                     funct7;
  rvcore_pkg::alu_op_e            f3_op;
  logic                           f3_ok;
  logic [rvcore_pkg::xlen-1:0]    imm_i;
  logic [rvcore_pkg::xlen-1:0]    imm_s;
  logic [rvcore_pkg::xlen-1:0]    imm_b;
  logic [rvcore_pkg::xlen-1:0]    imm_u;
  logic [rvcore_pkg::xlen-1:0]    imm_j;

  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'h000};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  // funct3 map shared by OP and OP-IMM
  always_comb begin
    f3_ok = 1'b1;
    case (funct3)
      3'b000:  f3_op = rvcore_pkg::add;
      3'b111:  f3_op = rvcore_pkg::and_op;
      3'b110:  f3_op = rvcore_pkg::or_op;
      3'b100:  f3_op = rvcore_pkg::xor_op;
      3'b010:  f3_op = rvcore_pkg::slt;
      3'b001:  f3_op = rvcore_pkg::sll;
      3'b101:  f3_op = rvcore_pkg::srl;
      default: begin
        f3_op = rvcore_pkg::add;
        f3_ok = 1'b0;  // SLTU
      end
    endcase
  end

  always_comb begin
    dec = '0;
    dec.opcode = rvcore_pkg::illegal;
    dec.alu_op = rvcore_pkg::add;
    dec.illegal = 1'b1;
    case (insn[6:0])
      rvcore_pkg::op: begin
        if (f3_ok && (funct7 == 7'b0000000 || (funct7 == 7'b0100000 && funct3 == 3'b000))) begin
          dec.opcode = rvcore_pkg::op;
          dec.alu_op = funct7[5] ? rvcore_pkg::sub : f3_op;
          dec.rs1 = insn[19:15];
          dec.rs2 = insn[24:20];
          dec.rd = insn[11:7];
          dec.reg_write = 1'b1;
          dec.illegal = 1'b0;
        end
      end
      rvcore_pkg::op_imm: begin
        if (f3_ok && funct3 != 3'b001 && funct3 != 3'b101) begin  // No immediate shifts
          dec.opcode = rvcore_pkg::op_imm;
          dec.alu_op = f3_op;
          dec.rs1 = insn[19:15];
          dec.rd = insn[11:7];
          dec.imm = imm_i;
          dec.use_imm = 1'b1;
          dec.reg_write = 1'b1;
          dec.illegal = 1'b0;
        end
      end
      rvcore_pkg::lui: begin
        dec.opcode = rvcore_pkg::lui;
        dec.alu_op = rvcore_pkg::pass_b;
        dec.rd = insn[11:7];
        dec.imm = imm_u;
        dec.use_imm = 1'b1;
        dec.reg_write = 1'b1;
        dec.illegal = 1'b0;
      end
      rvcore_pkg::jal: begin
        dec.opcode = rvcore_pkg::jal;
        dec.rd = insn[11:7];
        dec.imm = imm_j;
        dec.is_jump = 1'b1;
        dec.reg_write = 1'b1;
        dec.illegal = 1'b0;
      end
      rvcore_pkg::branch: begin
        if (funct3[2:1] == 2'b00) begin  // BEQ, BNE
          dec.opcode = rvcore_pkg::branch;
          dec.alu_op = rvcore_pkg::sub;
          dec.rs1 = insn[19:15];
          dec.rs2 = insn[24:20];
          dec.imm = imm_b;
          dec.is_branch = 1'b1;
          dec.branch_ne = funct3[0];
          dec.illegal = 1'b0;
        end
      end
      rvcore_pkg::load: begin
        if (funct3 == 3'b010) begin
          dec.opcode = rvcore_pkg::load;
          dec.rs1 = insn[19:15];
          dec.rd = insn[11:7];
          dec.imm = imm_i;
          dec.use_imm = 1'b1;
          dec.is_load = 1'b1;
          dec.reg_write = 1'b1;
          dec.illegal = 1'b0;
        end
      end
      rvcore_pkg::store: begin
        if (funct3 == 3'b010) begin
          dec.opcode = rvcore_pkg::store;
          dec.rs1 = insn[19:15];
          dec.rs2 = insn[24:20];
          dec.imm = imm_s;
          dec.use_imm = 1'b1;
          dec.is_store = 1'b1;
          dec.illegal = 1'b0;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== alu.sv ====
`default_nettype none

module alu (
  input  rvcore_pkg::alu_op_e         op,
  input  logic [rvcore_pkg::xlen-1:0] a,
  input  logic [rvcore_pkg::xlen-1:0] b,
  output logic [rvcore_pkg::xlen-1:0] result,
  output logic                        equal
);

  logic lt;

  assign lt = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      rvcore_pkg::add:    result = a + b;
      rvcore_pkg::sub:    result = a - b;
      rvcore_pkg::and_op: result = a & b;
      rvcore_pkg::or_op:  result = a | b;
      rvcore_pkg::xor_op: result = a ^ b;
      rvcore_pkg::slt:    result = {{(rvcore_pkg::xlen-1){1'b0}}, lt};
      rvcore_pkg::sll:    result = a << b[4:0];
      rvcore_pkg::srl:    result = a >> b[4:0];
      rvcore_pkg::pass_b: result = b;
      default:            result = a + b;
    endcase
  end

  // Branch compare always sees rs1 against rs2
  assign equal = a == b;

endmodule

`default_nettype wire

// ==== register_file.sv ====
`default_nettype none

module register_file (
  input  logic                        clock,
  input  logic                        rst_n,
  input  logic [4:0]                  rs1,
  input  logic [4:0]                  rs2,
  input  rvcore_pkg::reg_write_t      wr,
  output logic [rvcore_pkg::xlen-1:0] rs1_data,
  output logic [rvcore_pkg::xlen-1:0] rs2_data
);

  logic [rvcore_pkg::xlen-1:0] regs [1:31];  // x0 has no storage

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.en && wr.addr != 5'd0) begin
      regs[wr.addr] <= wr.data;
    end
  end

  // Same-cycle write is returned on the read ports
  assign rs1_data = (rs1 == 5'd0) ? '0 :
                    (wr.en && wr.addr == rs1) ? wr.data : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 :
                    (wr.en && wr.addr == rs2) ? wr.data : regs[rs2];

endmodule

`default_nettype wire

// ==== fetch_stage.sv ====
`default_nettype none

module fetch_stage (
  input  logic                  clock,
  input  logic                  rst_n,
  input  rvcore_pkg::imem_rsp_t imem_rsp,
  input  logic                  take,
  input  rvcore_pkg::redirect_t redirect,
  output rvcore_pkg::imem_req_t imem_req,
  output rvcore_pkg::fetch_t    fetch
);

  typedef enum logic [1:0] {
    idle,
    wait_mem,  // Request outstanding, buffer empty
    full       // Buffer holds an instruction for execute
  } state_e;

  state_e                      state;
  logic [rvcore_pkg::xlen-1:0] pc;
  logic [rvcore_pkg::xlen-1:0] target_q;
  logic [rvcore_pkg::xlen-1:0] buf_pc;
  logic [31:0]                 buf_insn;
  logic                        discard;
  logic                        rsp_fire;
  logic                        keep_rsp;

  assign imem_req.valid = state == wait_mem;
  assign imem_req.addr = pc;  // Held until ready
  assign rsp_fire = imem_req.valid && imem_rsp.ready;
  assign keep_rsp = rsp_fire && !discard && !redirect.valid;

  assign fetch.valid = state == full;
  assign fetch.pc = buf_pc;
  assign fetch.insn = buf_insn;

  // ******************************
  // Request sequencing
  // ******************************
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state <= idle;
      pc <= rvcore_pkg::reset_pc;
      discard <= 1'b0;
    end else begin
      case (state)
        idle: begin
          state <= wait_mem;
        end
        wait_mem: begin
          if (rsp_fire) begin
            discard <= 1'b0;
            if (redirect.valid) begin
              pc <= redirect.target;  // Drop it, refetch at once
            end else if (discard) begin
              pc <= target_q;
            end else begin
              pc <= pc + 32'd4;
              state <= full;
            end
          end else if (redirect.valid) begin
            discard <= 1'b1;  // Address must stay put until ready
          end
        end
        full: begin
          if (take) begin
            state <= wait_mem;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (redirect.valid) target_q <= redirect.target;
    if (keep_rsp) begin
      buf_pc <= pc;
      buf_insn <= imem_rsp.rdata;
    end
  end

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
`default_nettype none

module execute_stage (
  input  logic                  clock,
  input  logic                  rst_n,
  input  rvcore_pkg::fetch_t    fetch,
  input  rvcore_pkg::dmem_rsp_t dmem_rsp,
  output logic                  take,
  output rvcore_pkg::redirect_t redirect,
  output rvcore_pkg::dmem_req_t dmem_req,
  output rvcore_pkg::retire_t   retire
);

  typedef enum logic {
    idle,
    mem_wait
  } state_e;

  state_e                      state;
  rvcore_pkg::decoded_t        dec;
  rvcore_pkg::reg_write_t      wr;
  rvcore_pkg::retire_t         rec;
  rvcore_pkg::retire_t         fin;
  rvcore_pkg::retire_t         ret_q;
  rvcore_pkg::retire_t         hold_q;
  logic [rvcore_pkg::xlen-1:0] rs1_data;
  logic [rvcore_pkg::xlen-1:0] rs2_data;
  logic [rvcore_pkg::xlen-1:0] alu_b;
  logic [rvcore_pkg::xlen-1:0] alu_result;
  logic [rvcore_pkg::xlen-1:0] pc_plus4;
  logic [rvcore_pkg::xlen-1:0] target;
  logic [rvcore_pkg::xlen-1:0] next_pc;
  logic [rvcore_pkg::xlen-1:0] exp_pc;
  logic [rvcore_pkg::xlen-1:0] redir_target_q;
  logic [rvcore_pkg::xlen-1:0] wr_data_q;
  logic [4:0]                  wr_addr_q;
  logic [63:0]                 order_q;
  logic                        equal;
  logic                        taken;
  logic                        accept;
  logic                        is_mem;
  logic                        mem_done;
  logic                        retire_now;
  logic                        ret_valid_q;
  logic                        redir_valid_q;
  logic                        wr_en_q;

  decoder decoder_comp (
    .insn(fetch.insn),
    .dec (dec)
  );

  register_file register_file_comp (
    .clock   (clock),
    .rst_n   (rst_n),
    .rs1     (dec.rs1),
    .rs2     (dec.rs2),
    .wr      (wr),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  alu alu_comp (
    .op    (dec.alu_op),
    .a     (rs1_data),
    .b     (alu_b),
    .result(alu_result),
    .equal (equal)
  );

  // Wrong-path fetches are taken and dropped here
  assign take = state == idle;
  assign accept = fetch.valid && take && fetch.pc == exp_pc;
  assign is_mem = dec.opcode inside {rvcore_pkg::load, rvcore_pkg::store};
  assign mem_done = state == mem_wait && dmem_rsp.ready;
  assign retire_now = (accept && !is_mem) || mem_done;

  assign alu_b = dec.use_imm ? dec.imm : rs2_data;
  assign pc_plus4 = fetch.pc + 32'd4;
  assign target = fetch.pc + dec.imm;
  assign taken = dec.is_jump || (dec.is_branch && (equal ^ dec.branch_ne));
  assign next_pc = taken ? target : pc_plus4;

  // ******************************
  // Trace record
  // ******************************
  always_comb begin
    rec = '0;
    rec.valid = 1'b1;
    rec.order = order_q;
    rec.insn = fetch.insn;
    rec.trap = dec.illegal;
    rec.rs1_addr = dec.rs1;
    rec.rs2_addr = dec.rs2;
    rec.rs1_rdata = rs1_data;
    rec.rs2_rdata = rs2_data;
    rec.pc_rdata = fetch.pc;
    rec.pc_wdata = next_pc;
    if (dec.reg_write && dec.rd != 5'd0) begin
      rec.rd_addr = dec.rd;
      rec.rd_wdata = dec.is_jump ? pc_plus4 : alu_result;  // Link value for JAL
    end
    if (is_mem) begin
      rec.mem_addr = {alu_result[rvcore_pkg::xlen-1:2], 2'b00};
      rec.mem_rmask = {4{dec.is_load}};
      rec.mem_wmask = {4{dec.is_store}};
      rec.mem_wdata = dec.is_store ? rs2_data : '0;
    end
  end

  // Completes a held load or store with the response
  always_comb begin
    fin = hold_q;
    if (hold_q.mem_rmask != 4'h0) fin.mem_rdata = dmem_rsp.rdata;
    if (hold_q.rd_addr != 5'd0) fin.rd_wdata = dmem_rsp.rdata;
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state <= idle;
      exp_pc <= rvcore_pkg::reset_pc;
      order_q <= '0;
      ret_valid_q <= 1'b0;
      redir_valid_q <= 1'b0;
      wr_en_q <= 1'b0;
    end else begin
      ret_valid_q <= retire_now;
      redir_valid_q <= accept && taken;
      wr_en_q <= (accept && !is_mem && rec.rd_addr != 5'd0) ||
                 (mem_done && hold_q.rd_addr != 5'd0);
      if (accept) exp_pc <= next_pc;
      if (accept && is_mem) begin
        state <= mem_wait;
      end else if (mem_done) begin
        state <= idle;
      end
      if (retire_now) order_q <= order_q + 64'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (accept && is_mem) hold_q <= rec;
    if (accept) redir_target_q <= target;
    if (accept && !is_mem) begin
      ret_q <= rec;
      wr_addr_q <= rec.rd_addr;
      wr_data_q <= rec.rd_wdata;
    end else if (mem_done) begin
      ret_q <= fin;
      wr_addr_q <= fin.rd_addr;
      wr_data_q <= fin.rd_wdata;
    end
  end

  // ******************************
  // Outputs
  // ******************************
  always_comb begin
    retire = ret_q;
    retire.valid = ret_valid_q;
  end

  assign wr.en = wr_en_q;
  assign wr.addr = wr_addr_q;
  assign wr.data = wr_data_q;

  assign redirect.valid = redir_valid_q;
  assign redirect.target = redir_target_q;

  assign dmem_req.valid = state == mem_wait;
  assign dmem_req.addr = hold_q.mem_addr;
  assign dmem_req.wdata = hold_q.mem_wdata;
  assign dmem_req.wstrb = hold_q.mem_wmask;

endmodule

`default_nettype wire

// ==== rvcore.sv ====
`default_nettype none

module rvcore (
  input  logic                  clock,
  input  logic                  rst_n,
  input  rvcore_pkg::imem_rsp_t imem_rsp,
  input  rvcore_pkg::dmem_rsp_t dmem_rsp,
  output rvcore_pkg::imem_req_t imem_req,
  output rvcore_pkg::dmem_req_t dmem_req,
  output rvcore_pkg::retire_t   retire
);

  rvcore_pkg::fetch_t    fetch;
  rvcore_pkg::redirect_t redirect;
  logic                  take;

  // ******************************
  // Pipeline stages
  // ******************************
  fetch_stage fetch_stage_comp (
    .clock   (clock),
    .rst_n   (rst_n),
    .imem_rsp(imem_rsp),
    .take    (take),
    .redirect(redirect),
    .imem_req(imem_req),
    .fetch   (fetch)
  );

  // Decoder, ALU and registers live inside execute
  execute_stage execute_stage_comp (
    .clock   (clock),
    .rst_n   (rst_n),
    .fetch   (fetch),
    .dmem_rsp(dmem_rsp),
    .take    (take),
    .redirect(redirect),
    .dmem_req(dmem_req),
    .retire  (retire)
  );

endmodule

`default_nettype wire

// ==== rvcore_assert.sv ====
`default_nettype none

module rvcore_assert (
  input logic                  clock,
  input logic                  rst_n,
  input rvcore_pkg::imem_req_t imem_req,
  input rvcore_pkg::imem_rsp_t imem_rsp,
  input rvcore_pkg::dmem_req_t dmem_req,
  input rvcore_pkg::dmem_rsp_t dmem_rsp,
  input rvcore_pkg::retire_t   retire
);

  // ******************************
  // Handshake stability
  // ******************************
  imem_hold: assert property (@(posedge clock) disable iff (!rst_n)
    imem_req.valid && !imem_rsp.ready |=> imem_req.valid && $stable(imem_req.addr))
    else $error("imem request changed before ready");

  dmem_hold: assert property (@(posedge clock) disable iff (!rst_n)
    dmem_req.valid && !dmem_rsp.ready |=> $stable(dmem_req))
    else $error("dmem request changed before ready");

  // Covers reset itself and the first cycle out of it
  retire_quiet: assert property (@(posedge clock) !rst_n |=> !retire.valid)
    else $error("retire valid during or right after reset");

endmodule

bind rvcore rvcore_assert asrt0 (
  .clock   (clock),
  .rst_n   (rst_n),
  .imem_req(imem_req),
  .imem_rsp(imem_rsp),
  .dmem_req(dmem_req),
  .dmem_rsp(dmem_rsp),
  .retire  (retire)
);

`default_nettype wire

// ==== tb_rvcore.sv ====
`default_nettype none

module tb_rvcore;

  localparam int num_retire = 2000;
  localparam int worst_cycles = 16;  // Fetch wait, refetch and data wait together

  logic                  clock;
  logic                  rst_n;
  rvcore_pkg::imem_req_t imem_req;
  rvcore_pkg::imem_rsp_t imem_rsp;
  rvcore_pkg::dmem_req_t dmem_req;
  rvcore_pkg::dmem_rsp_t dmem_rsp;
  rvcore_pkg::retire_t   retire;

  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];
  logic [31:0] mdmem [0:255];  // Model copy of data memory
  logic [31:0] x [0:31];
  logic [31:0] mpc;
  logic [31:0] lfsr;
  logic [1:0]  idelay;
  logic [1:0]  ddelay;
  int          count;

  rvcore dut0 (
    .clock   (clock),
    .rst_n   (rst_n),
    .imem_rsp(imem_rsp),
    .dmem_rsp(dmem_rsp),
    .imem_req(imem_req),
    .dmem_req(dmem_req),
    .retire  (retire)
  );

  // ******************************
  // Helpers
  // ******************************
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);  // Galois step
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s actual=%h expected=%h", name, actual, expected);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic neg,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return neg ? a - b : a + b;
      3'b111:  return a & b;
      3'b110:  return a | b;
      3'b100:  return a ^ b;
      3'b010:  return {31'd0, $signed(a) < $signed(b)};
      3'b001:  return a << b[4:0];
      default: return a >> b[4:0];
    endcase
  endfunction

  function automatic logic [31:0] make_insn();
    logic [3:0]  kind;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        alt;
    logic [31:0] off;
    logic [11:0] imm;
    kind = 4'(draw_bits(4));
    f3 = 3'(draw_bits(3));
    rd = 5'(draw_bits(3));
    rs1 = 5'(draw_bits(3));
    rs2 = 5'(draw_bits(3));
    alt = draw_bits(1) == 1;
    off = (draw_bits(3) + 1) * 4;  // Forward only, so no endless loops
    imm = {4'd0, 6'(draw_bits(6)), 2'b00};
    case (kind)
      4'd0, 4'd1, 4'd2, 4'd15: begin
        if (f3 == 3'b011) f3 = 3'b000;
        return {1'b0, f3 == 3'b000 && alt, 5'd0, rs2, rs1, f3, rd, 7'b0110011};
      end
      4'd3, 4'd4, 4'd5: begin
        if (f3 == 3'b001 || f3 == 3'b101 || f3 == 3'b011) f3 = 3'b000;
        return {12'(draw_bits(12)), rs1, f3, rd, 7'b0010011};
      end
      4'd6:         return {20'(draw_bits(20)), rd, 7'b0110111};
      4'd7:         return {1'b0, off[10:1], 9'd0, rd, 7'b1101111};
      4'd8, 4'd9:   return {1'b0, off[10:5], rs2, rs1, 2'b00, alt, off[4:1], 1'b0,
                            7'b1100011};
      4'd10, 4'd11: return {imm, 5'd0, 3'b010, rd, 7'b0000011};
      4'd12, 4'd13: return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
      default:      return {25'(draw_bits(25)), 7'b1110011};  // SYSTEM, unsupported
    endcase
  endfunction

  // ******************************
  // Reference model
  // ******************************
  task automatic model_step();
    logic [31:0] insn;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] ldata;
    logic [31:0] npc;
    logic [31:0] addr;
    logic [31:0] imm_i;
    logic [3:0]  rmask;
    logic [3:0]  wmask;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic        legal;
    logic        use1;
    logic        use2;
    logic        wr;
    insn = imem[mpc[9:2]];
    rd = insn[11:7];
    f3 = insn[14:12];
    a = x[insn[19:15]];
    b = x[insn[24:20]];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    npc = mpc + 4;
    res = '0;
    ldata = '0;
    addr = '0;
    rmask = '0;
    wmask = '0;
    legal = 1'b0;
    use1 = 1'b0;
    use2 = 1'b0;
    wr = 1'b0;
    case (insn[6:0])
      7'b0110011: begin
        legal = f3 != 3'b011 && (insn[31:25] == 0 || (insn[31:25] == 7'h20 && f3 == 0));
        res = alu_ref(f3, insn[30], a, b);
        {use1, use2, wr} = 3'b111;
      end
      7'b0010011: begin
        legal = f3 inside {3'b000, 3'b111, 3'b110, 3'b100, 3'b010};
        res = alu_ref(f3, 1'b0, a, imm_i);
        {use1, wr} = 2'b11;
      end
      7'b0110111: begin
        legal = 1'b1;
        res = {insn[31:12], 12'h000};
        wr = 1'b1;
      end
      7'b1101111: begin
        legal = 1'b1;
        res = mpc + 4;  // Link
        npc = mpc + {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
        wr = 1'b1;
      end
      7'b1100011: begin
        legal = f3[2:1] == 2'b00;
        {use1, use2} = 2'b11;
        if ((a == b) ^ f3[0]) begin
          npc = mpc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
        end
      end
      7'b0000011: begin
        legal = f3 == 3'b010;
        addr = (a + imm_i) & ~32'd3;
        ldata = mdmem[addr[9:2]];
        res = ldata;
        rmask = 4'hf;
        {use1, wr} = 2'b11;
      end
      7'b0100011: begin
        legal = f3 == 3'b010;
        addr = (a + {{20{insn[31]}}, insn[31:25], insn[11:7]}) & ~32'd3;
        wmask = 4'hf;
        {use1, use2} = 2'b11;
      end
      default: legal = 1'b0;
    endcase
    if (!legal) begin
      {use1, use2, wr} = 3'b000;
      {addr, rmask, wmask} = '0;
      npc = mpc + 4;
    end
    if (!wr || rd == 0) begin
      rd = 0;
      res = '0;
    end
    check_value("order", retire.order, count);
    check_value("insn", retire.insn, insn);
    check_value("trap", retire.trap, !legal);
    check_value("pc_rdata", retire.pc_rdata, mpc);
    check_value("pc_wdata", retire.pc_wdata, npc);
    check_value("rs1_addr", retire.rs1_addr, use1 ? insn[19:15] : 5'd0);
    check_value("rs2_addr", retire.rs2_addr, use2 ? insn[24:20] : 5'd0);
    check_value("rs1_rdata", retire.rs1_rdata, use1 ? a : 0);
    check_value("rs2_rdata", retire.rs2_rdata, use2 ? b : 0);
    check_value("rd_addr", retire.rd_addr, rd);
    check_value("rd_wdata", retire.rd_wdata, res);
    check_value("mem_addr", retire.mem_addr, addr);
    check_value("mem_rmask", retire.mem_rmask, rmask);
    check_value("mem_wmask", retire.mem_wmask, wmask);
    check_value("mem_wdata", retire.mem_wdata, wmask != 0 ? b : 0);
    check_value("mem_rdata", retire.mem_rdata, rmask != 0 ? ldata : 32'd0);
    if (wmask != 0) mdmem[addr[9:2]] = b;
    if (rd != 0) x[rd] = res;
    mpc = npc;
  endtask

  // ******************************
  // Clock, reset, memories
  // ******************************
  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  initial begin
    rst_n = 1'b0;
    imem_rsp = '0;
    dmem_rsp = '0;
    lfsr = 32'd94998;
    mpc = '0;
    count = 0;
    idelay = '0;
    ddelay = '0;
    for (int i = 0; i < 32; i++) x[i] = '0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = make_insn();
      dmem[i] = i * 32'h9e37_79b1 + 32'h1234_5671;
      mdmem[i] = dmem[i];
    end
    repeat (4) @(posedge clock);
    rst_n <= 1'b1;
  end

  // Instruction and data memory responders
  always @(posedge clock) begin
    if (rst_n) begin
      if (imem_rsp.ready) begin
        imem_rsp.ready <= 1'b0;
        idelay <= 2'(draw_bits(2));
      end else if (imem_req.valid) begin
        if (idelay == 0) begin
          imem_rsp.ready <= 1'b1;
          imem_rsp.rdata <= imem[imem_req.addr[9:2]];
        end else idelay <= idelay - 1;
      end
      if (dmem_rsp.ready) begin
        dmem_rsp.ready <= 1'b0;
        ddelay <= 2'(draw_bits(2));
        if (dmem_req.wstrb == 4'hf) dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
      end else if (dmem_req.valid) begin
        if (ddelay == 0) begin
          dmem_rsp.ready <= 1'b1;
          dmem_rsp.rdata <= dmem[dmem_req.addr[9:2]];
        end else ddelay <= ddelay - 1;
      end
    end
  end

  always @(posedge clock) begin
    if (rst_n && retire.valid) begin
      model_step();
      count = count + 1;
      if (count == num_retire) begin
        $display("TEST OK");
        $finish;
      end
    end
  end

  initial begin
    #(num_retire * worst_cycles * 20 + 20000);
    $display("Timeout: too few instructions retired before the time limit");
    $display("TEST FAILED");
    $fatal(1);
  end

endmodule

`default_nettype wire

// ==== rvcore.f ====
rvcore_pkg.sv
decoder.sv
alu.sv
register_file.sv
fetch_stage.sv
execute_stage.sv
rvcore.sv
rvcore_assert.sv
tb_rvcore.sv

// ==== run.sh ====
#!/bin/sh
# Build and run with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f rvcore.f \
  --top-module tb_rvcore -o sim_rvcore > sim.log 2>&1 &&
  ./obj_dir/sim_rvcore >> sim.log 2>&1
grep -q "^TEST OK$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
